// File: pdp_pool_stimulus.mem
// one input beat per line with type cpos first last lc lane0 lane1
// then expected pool_size pool_lc data check flag lane0 lane1 (all hex)
// max window
1 0 1 0 0 00A 7FB 0 0 0 000 000
1 1 1 0 0 780 07F 0 0 0 000 000
1 2 1 0 0 000 000 0 0 0 000 000
1 3 1 0 0 7CE 7C4 0 0 0 000 000
1 4 1 0 0 064 003 0 0 0 000 000
1 5 1 0 0 7FF 7FE 0 0 0 000 000
1 6 1 0 0 040 7C0 0 0 0 000 000
1 7 1 0 0 007 008 0 0 0 000 000
1 0 0 1 1 014 7FD 0 1 1 014 7FD
1 1 0 1 1 781 07E 0 1 1 781 07F
1 2 0 1 1 7FF 001 0 1 1 000 001
1 3 0 1 1 7BA 7D8 0 1 1 7CE 7D8
1 4 0 1 1 063 004 0 1 1 064 004
1 5 0 1 1 7FF 7FE 0 1 1 7FF 7FE
1 6 0 1 1 7C0 040 0 1 1 040 040
1 7 0 1 1 009 006 0 1 1 009 008
// min window
2 0 1 0 0 00A 7FB 0 0 0 000 000
2 1 1 0 0 780 07F 0 0 0 000 000
2 2 1 0 0 005 7F7 0 0 0 000 000
2 3 1 0 0 7CE 7C4 0 0 0 000 000
2 4 1 0 0 001 002 0 0 0 000 000
2 5 1 0 0 79C 064 0 0 0 000 000
2 6 1 0 0 000 7FF 0 0 0 000 000
2 7 1 0 0 021 7DF 0 0 0 000 000
2 0 0 1 1 014 7FD 0 1 1 00A 7FB
2 1 0 1 1 781 07E 0 1 1 780 07E
2 2 0 1 1 7FA 009 0 1 1 7FA 7F7
2 3 0 1 1 7BA 7D8 0 1 1 7BA 7C4
2 4 0 1 1 002 001 0 1 1 001 001
2 5 0 1 1 79D 063 0 1 1 79C 063
2 6 0 1 1 000 000 0 1 1 000 7FF
2 7 0 1 1 7DF 021 0 1 1 7DF 7DF
// mean window, some lane sums wrap
0 0 1 0 0 00A 7FB 0 0 0 000 000
0 1 1 0 0 780 07F 0 0 0 000 000
0 2 1 0 0 3FF 400 0 0 0 000 000
0 3 1 0 0 258 5A8 0 0 0 000 000
0 4 1 0 0 7FF 7FF 0 0 0 000 000
0 5 1 0 0 064 79C 0 0 0 000 000
0 6 1 0 0 000 000 0 0 0 000 000
0 7 1 0 0 7C0 040 0 0 0 000 000
0 0 0 1 1 014 7FD 0 1 1 01E 7F8
0 1 0 1 1 781 07E 0 1 1 701 0FD
0 2 0 1 1 001 7FF 0 1 1 400 3FF
0 3 0 1 1 1F4 60C 0 1 1 44C 3B4
0 4 0 1 1 001 001 0 1 1 000 000
0 5 0 1 1 01B 7E4 0 1 1 07F 780
0 6 0 1 1 000 000 0 1 1 000 000
0 7 0 1 1 7C0 040 0 1 1 780 080

// File: pdp_pool.f
pdp_pool_pkg.sv
pdp_pool_alu.sv
pdp_pool_din.sv
pdp_pool_pipe.sv
pdp_pool_line_buf.sv
pdp_pool_out_seq.sv
pdp_pool_core.sv
pdp_pool_checker.sv
pdp_pool_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the pooling testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pdp_pool_tb \
  -f pdp_pool.f -o pdp_pool_sim || exit 1
out=$(./obj_dir/pdp_pool_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$" && exit 0 || exit 1

// File: pdp_pool_tb.sv
// testbench for the one-dimensional pooling stage
// replays the stimulus file under random output back-pressure

`timescale 1ns/1ps

module pdp_pool_tb
  import pdp_pool_pkg::*;
();

  // beats in the stimulus file, hex words per beat
  localparam int NUM_BEATS      = 48;
  localparam int NUM_COLS       = 12;
  // 8 cycles per beat covers the worst stall runs
  localparam int TIMEOUT_CYCLES = NUM_BEATS * 8 + 100;

  logic                 nvdla_core_clk;
  logic                 nvdla_core_rstn;
  pool_type_e           pooling_type;
  logic                 din_valid;
  logic                 din_ready;
  logic [DATA_W-1:0]    din_data;
  logic [BUF_SEL_W-1:0] din_cpos;
  logic                 din_first;
  logic                 din_last;
  logic                 din_lc;
  logic                 pool_valid;
  logic                 pool_ready;
  logic [DATA_W-1:0]    pool_data;
  logic [SIZE_W-1:0]    pool_size;
  logic                 pool_lc;

  // columns 0..6 input beat, 7..11 expected output
  logic [11:0] stim_mem [NUM_BEATS*NUM_COLS];
  logic [31:0] rng_state;
  int          in_idx;
  int          out_idx;
  int          cycle_cnt;

  pdp_pool_core i_pdp_pool_core (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .pooling_type    (pooling_type),
    .din_valid       (din_valid),
    .din_ready       (din_ready),
    .din_data        (din_data),
    .din_cpos        (din_cpos),
    .din_first       (din_first),
    .din_last        (din_last),
    .din_lc          (din_lc),
    .pool_valid      (pool_valid),
    .pool_ready      (pool_ready),
    .pool_data       (pool_data),
    .pool_size       (pool_size),
    .pool_lc         (pool_lc)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t: output beat %0d %s is 0x%0h, expected 0x%0h",
               $time, out_idx, what, got, expected);
      end_with_failure();
    end
  endtask

  // puts beat idx of the file on the input port
  task automatic drive_beat(input int idx);
    int base;
    base = idx * NUM_COLS;
    pooling_type <= pool_type_e'(stim_mem[base][1:0]);
    din_cpos     <= stim_mem[base+1][BUF_SEL_W-1:0];
    din_first    <= stim_mem[base+2][0];
    din_last     <= stim_mem[base+3][0];
    din_lc       <= stim_mem[base+4][0];
    din_data     <= {stim_mem[base+6][LANE_W-1:0], stim_mem[base+5][LANE_W-1:0]};
    din_valid    <= 1'b1;
  endtask

  // data only checked where the file flags it, i.e. last beats
  task automatic check_output(input int idx);
    int base;
    base = idx * NUM_COLS;
    compare_value("pool_size", 32'(pool_size), 32'(stim_mem[base+7]));
    compare_value("pool_lc", 32'(pool_lc), 32'(stim_mem[base+8]));
    if (stim_mem[base+9][0]) begin
      compare_value("pool_data", 32'(pool_data),
                    {10'd0, stim_mem[base+11][LANE_W-1:0], stim_mem[base+10][LANE_W-1:0]});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock, back-pressure, timeout
  //////////////////////////////////////////////////////////////////////
  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  always @(posedge nvdla_core_clk) begin
    rng_state  <= xorshift32(rng_state);
    pool_ready <= rng_state[0];
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d output beats seen",
               cycle_cnt, out_idx, NUM_BEATS);
      end_with_failure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output scoreboard, beats come back in input order
  //////////////////////////////////////////////////////////////////////
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn && pool_valid && pool_ready) begin
      if (out_idx >= NUM_BEATS) begin
        $display("unexpected output beat after all %0d expected beats", NUM_BEATS);
        end_with_failure();
      end else begin
        check_output(out_idx);
        out_idx = out_idx + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus replay
  //////////////////////////////////////////////////////////////////////
  initial begin
    nvdla_core_rstn = 1'b0;
    pooling_type    = POOL_MEAN;
    din_valid       = 1'b0;
    din_data        = '0;
    din_cpos        = '0;
    din_first       = 1'b0;
    din_last        = 1'b0;
    din_lc          = 1'b0;
    pool_ready      = 1'b0;
    rng_state       = 32'h9046_2ccb;
    in_idx          = 0;
    out_idx         = 0;
    cycle_cnt       = 0;
    $readmemh("pdp_pool_stimulus.mem", stim_mem);

    repeat (4) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    drive_beat(0);

    // next beat only once the current one is taken
    while (in_idx < NUM_BEATS) begin
      @(posedge nvdla_core_clk);
      if (din_valid && din_ready) begin
        in_idx = in_idx + 1;
        if (in_idx < NUM_BEATS) begin
          drive_beat(in_idx);
        end else begin
          din_valid <= 1'b0;
        end
      end
    end

    // drain, then nothing may still wait at the output
    wait (out_idx == NUM_BEATS);
    repeat (10) @(posedge nvdla_core_clk);
    if (!pool_valid) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("output beat still pending after all %0d expected beats", NUM_BEATS);
      end_with_failure();
    end
  end

endmodule

// File: pdp_pool_checker.sv
// handshake checks for the pooling top level
// bound into the core

`timescale 1ns/1ps

module pdp_pool_checker
  import pdp_pool_pkg::*;
(
  input logic              nvdla_core_clk,
  input logic              nvdla_core_rstn,
  input logic              din_valid,
  input logic              din_ready,
  input logic              pool_valid,
  input logic              pool_ready,
  input logic [DATA_W-1:0] pool_data,
  input logic [SIZE_W-1:0] pool_size,
  input logic              pool_lc
);

  // beats accepted and not yet delivered, equals filled stages
  int inflight;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      inflight <= 0;
    end else begin
      inflight <= inflight + int'(din_valid && din_ready) - int'(pool_valid && pool_ready);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////

  // output held while stalled
  a_hold_while_stalled: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    pool_valid && !pool_ready |=>
      pool_valid && $stable(pool_data) && $stable(pool_size) && $stable(pool_lc)
  ) else $error("pool output changed while stalled");

  a_no_valid_in_reset: assert property (
    @(posedge nvdla_core_clk) !nvdla_core_rstn |-> !pool_valid
  ) else $error("pool_valid high during reset");

  // a free stage always takes a beat
  a_ready_when_not_full: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    inflight < PIPE_STAGES |-> din_ready
  ) else $error("din_ready low with a free pipe stage");

endmodule

bind pdp_pool_core pdp_pool_checker u_checker (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .din_valid       (din_valid),
  .din_ready       (din_ready),
  .pool_valid      (pool_valid),
  .pool_ready      (pool_ready),
  .pool_data       (pool_data),
  .pool_size       (pool_size),
  .pool_lc         (pool_lc)
);

// File: pdp_pool_core.sv
// planar pooling, one-dimensional stage top level
// input stage, latency pipe, partial buffers and output sequencer

`timescale 1ns/1ps

module pdp_pool_core
  import pdp_pool_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  // configuration, quasi static
  input  pool_type_e           pooling_type,
  // input beats
  input  logic                 din_valid,
  output logic                 din_ready,
  input  logic [DATA_W-1:0]    din_data,
  input  logic [BUF_SEL_W-1:0] din_cpos,
  input  logic                 din_first,
  input  logic                 din_last,
  input  logic                 din_lc,
  // pooled output
  output logic                 pool_valid,
  input  logic                 pool_ready,
  output logic [DATA_W-1:0]    pool_data,
  output logic [SIZE_W-1:0]    pool_size,
  output logic                 pool_lc
);

  //////////////////////////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////////////////////////

  // partial read for the input stage
  logic [BUF_SEL_W-1:0] rd_cpos;
  logic [DATA_W-1:0]    cur_data;
  // pipe input
  logic                 in_valid;
  logic                 in_ready;
  pipe_beat_t           in_beat;
  // pipe exit
  logic                 out_valid;
  logic                 out_ready;
  pipe_beat_t           out_beat;
  logic                 beat_fire;
  // output read
  logic [BUF_SEL_W-1:0] rd_cnt;
  logic [DATA_W-1:0]    cnt_data;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////
  pdp_pool_din u_din (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .din_valid       (din_valid),
    .din_ready       (din_ready),
    .din_data        (din_data),
    .din_cpos        (din_cpos),
    .din_first       (din_first),
    .din_last        (din_last),
    .din_lc          (din_lc),
    .pooling_type    (pooling_type),
    .rd_cpos         (rd_cpos),
    .cur_data        (cur_data),
    .in_valid        (in_valid),
    .in_beat         (in_beat),
    .in_ready        (in_ready)
  );

  pdp_pool_pipe u_pipe (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (in_valid),
    .in_beat         (in_beat),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_beat        (out_beat),
    .out_ready       (out_ready)
  );

  pdp_pool_line_buf u_line_buf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .rd_cpos         (rd_cpos),
    .cur_data        (cur_data),
    .out_beat        (out_beat),
    .beat_fire       (beat_fire),
    .rd_cnt          (rd_cnt),
    .cnt_data        (cnt_data)
  );

  pdp_pool_out_seq u_out_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .out_valid       (out_valid),
    .out_beat        (out_beat),
    .out_ready       (out_ready),
    .beat_fire       (beat_fire),
    .rd_cnt          (rd_cnt),
    .cnt_data        (cnt_data),
    .pool_valid      (pool_valid),
    .pool_data       (pool_data),
    .pool_size       (pool_size),
    .pool_lc         (pool_lc),
    .pool_ready      (pool_ready)
  );

endmodule

// File: pdp_pool_out_seq.sv
// pooling output sequencer
// window counter, output handshake and output field assembly

`timescale 1ns/1ps

module pdp_pool_out_seq
  import pdp_pool_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  // pipe exit
  input  logic                 out_valid,
  input  pipe_beat_t           out_beat,
  output logic                 out_ready,
  output logic                 beat_fire,
  // buffer read
  output logic [BUF_SEL_W-1:0] rd_cnt,
  input  logic [DATA_W-1:0]    cnt_data,
  // output port
  output logic                 pool_valid,
  output logic [DATA_W-1:0]    pool_data,
  output logic [SIZE_W-1:0]    pool_size,
  output logic                 pool_lc,
  input  logic                 pool_ready
);

  logic [BUF_SEL_W-1:0] cnt_q;

  // output valid is the pipe exit valid
  assign pool_valid = out_valid;
  assign out_ready  = ~out_valid | pool_ready;
  assign beat_fire  = out_valid & pool_ready;

  //////////////////////////////////////////////////////////////////////
  // window counter, steps on each last beat
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_q <= '0;
    end else if (beat_fire & out_beat.last) begin
      if (cnt_q == BUF_SEL_W'(NUM_BUF - 1)) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign rd_cnt = cnt_q;

  // output fields
  assign pool_data = cnt_data;
  assign pool_size = out_beat.size;
  assign pool_lc   = out_beat.lc;

endmodule

// File: pdp_pool_line_buf.sv
// per channel group partial buffers
// read for the input stage, written at pipe exit, read with bypass for output

`timescale 1ns/1ps

module pdp_pool_line_buf
  import pdp_pool_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  // input stage read
  input  logic [BUF_SEL_W-1:0] rd_cpos,
  output logic [DATA_W-1:0]    cur_data,
  // pipe exit write
  input  pipe_beat_t           out_beat,
  input  logic                 beat_fire,
  // output read
  input  logic [BUF_SEL_W-1:0] rd_cnt,
  output logic [DATA_W-1:0]    cnt_data
);

  logic [DATA_W-1:0] buf_q [NUM_BUF];
  logic [DATA_W-1:0] wr_data;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // first beat of a window restarts the partial
  assign wr_data = out_beat.first ? out_beat.raw : out_beat.pooled;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int i = 0; i < NUM_BUF; i++) begin
        buf_q[i] <= '0;
      end
    end else if (beat_fire) begin
      buf_q[out_beat.cpos] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // no bypass needed here
  // the previous update of this group left the pipe long ago
  assign cur_data = buf_q[rd_cpos];

  // exit beat shows its new partial in the same cycle
  // held on address match alone so the output stays put while stalled
  always_comb begin
    if (out_beat.cpos == rd_cnt) begin
      cnt_data = wr_data;
    end else begin
      cnt_data = buf_q[rd_cnt];
    end
  end

endmodule

// File: pdp_pool_pipe.sv
// pooling latency pipe
// PIPE_STAGES registered valid/ready stages carrying one beat each

`timescale 1ns/1ps

module pdp_pool_pipe
  import pdp_pool_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  // upstream side
  input  logic       in_valid,
  input  pipe_beat_t in_beat,
  output logic       in_ready,
  // downstream side
  output logic       out_valid,
  output pipe_beat_t out_beat,
  input  logic       out_ready
);

  // index 0 is the pipe input, PIPE_STAGES the last register
  logic [PIPE_STAGES:0] vld;
  logic [PIPE_STAGES:0] rdy;
  pipe_beat_t           dat [PIPE_STAGES+1];

  assign vld[0]           = in_valid;
  assign dat[0]           = in_beat;
  assign rdy[PIPE_STAGES] = out_ready;

  //////////////////////////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////////////////////////
  for (genvar s = 1; s <= PIPE_STAGES; s++) begin : g_stage
    // stage takes a beat when empty or draining
    assign rdy[s-1] = ~vld[s] | rdy[s];

    always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
      if (!nvdla_core_rstn) begin
        vld[s] <= 1'b0;
      end else if (rdy[s-1]) begin
        vld[s] <= vld[s-1];
      end
    end

    // payload moves only on a transfer into this stage
    always_ff @(posedge nvdla_core_clk) begin
      if (vld[s-1] & rdy[s-1]) begin
        dat[s] <= dat[s-1];
      end
    end
  end

  assign in_ready  = rdy[0];
  assign out_valid = vld[PIPE_STAGES];
  assign out_beat  = dat[PIPE_STAGES];

endmodule

// File: pdp_pool_din.sv
// pooling input stage
// accepts beats, tracks the pooling size and builds the pipe beat

`timescale 1ns/1ps

module pdp_pool_din
  import pdp_pool_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  // input beat
  input  logic                 din_valid,
  output logic                 din_ready,
  input  logic [DATA_W-1:0]    din_data,
  input  logic [BUF_SEL_W-1:0] din_cpos,
  input  logic                 din_first,
  input  logic                 din_last,
  input  logic                 din_lc,
  input  pool_type_e           pooling_type,
  // partial read from the line buffer
  output logic [BUF_SEL_W-1:0] rd_cpos,
  input  logic [DATA_W-1:0]    cur_data,
  // pipe input
  output logic                 in_valid,
  output pipe_beat_t           in_beat,
  input  logic                 in_ready
);

  logic              load_din;
  logic [SIZE_W-1:0] size_q;
  logic [DATA_W-1:0] pooled;

  // handshake straight to the pipe
  assign in_valid  = din_valid;
  assign din_ready = in_ready;
  assign load_din  = din_valid & in_ready;

  //////////////////////////////////////////////////////////////////////
  // pooling function
  //////////////////////////////////////////////////////////////////////

  // partial of this channel group
  assign rd_cpos = din_cpos;

  pdp_pool_alu u_alu (
    .pooling_type (pooling_type),
    .op_a         (cur_data),
    .op_b         (din_data),
    .result       (pooled)
  );

  //////////////////////////////////////////////////////////////////////
  // pooling real size
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      size_q <= '0;
    end else if (load_din & din_lc) begin
      // window done on its last line
      if (din_last) begin
        size_q <= '0;
      end else begin
        size_q <= size_q + 1'b1;
      end
    end
  end

  // beat carries the pre-update size
  assign in_beat.last   = din_last;
  assign in_beat.size   = size_q;
  assign in_beat.cpos   = din_cpos;
  assign in_beat.lc     = din_lc;
  assign in_beat.first  = din_first;
  assign in_beat.raw    = din_data;
  assign in_beat.pooled = pooled;

endmodule

// File: pdp_pool_alu.sv
// pooling lane operator
// per-lane signed max, signed min or wrapping sum of two packed operands

`timescale 1ns/1ps

module pdp_pool_alu
  import pdp_pool_pkg::*;
(
  input  pool_type_e        pooling_type,
  // running partial
  input  logic [DATA_W-1:0] op_a,
  // new input lanes
  input  logic [DATA_W-1:0] op_b,
  output logic [DATA_W-1:0] result
);

  //////////////////////////////////////////////////////////////////////
  // one operator per lane
  //////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    logic signed [LANE_W-1:0] lane_a;
    logic signed [LANE_W-1:0] lane_b;
    logic signed [LANE_W-1:0] lane_res;

    assign lane_a = op_a[i*LANE_W +: LANE_W];
    assign lane_b = op_b[i*LANE_W +: LANE_W];

    always_comb begin
      case (pooling_type)
        // mean pooling accumulates, wraps at lane width
        POOL_MEAN: lane_res = lane_a + lane_b;
        POOL_MAX:  lane_res = (lane_a > lane_b) ? lane_a : lane_b;
        POOL_MIN:  lane_res = (lane_a < lane_b) ? lane_a : lane_b;
        // reserved code
        default:   lane_res = '0;
      endcase
    end

    assign result[i*LANE_W +: LANE_W] = lane_res;
  end

endmodule

// File: pdp_pool_pkg.sv
// planar pooling engine, one-dimensional stage
// shared widths, counts, pooling type codes and the pipe beat layout

package pdp_pool_pkg;

  //////////////////////////////////////////////////////////////////////
  // lane and beat geometry
  //////////////////////////////////////////////////////////////////////

  // lanes per input beat (throughput)
  localparam int NUM_LANES   = 2;
  // element width 8 plus 3 guard bits for sums
  localparam int LANE_W      = 11;
  localparam int DATA_W      = NUM_LANES * LANE_W;

  // one partial per channel group, atomic size / throughput
  localparam int NUM_BUF     = 8;
  localparam int BUF_SEL_W   = 3;

  // pooling size counter width
  localparam int SIZE_W      = 3;

  // modelled on the adder latency
  localparam int PIPE_STAGES = 4;

  //////////////////////////////////////////////////////////////////////
  // pooling type, code 3 gives zero lanes
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    POOL_MEAN = 2'd0,
    POOL_MAX  = 2'd1,
    POOL_MIN  = 2'd2
  } pool_type_e;

  //////////////////////////////////////////////////////////////////////
  // beat carried through the pipe, msb first
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                 last;
    logic [SIZE_W-1:0]    size;
    logic [BUF_SEL_W-1:0] cpos;
    logic                 lc;
    logic                 first;
    // input lanes as received, used on a first beat
    logic [DATA_W-1:0]    raw;
    // lanes combined with the running partial
    logic [DATA_W-1:0]    pooled;
  } pipe_beat_t;

endpackage
